/* design/thumb_isa_pkg.sv */
package thumb_isa_pkg;

    localparam int INSTR_W    = 16;
    localparam int REG_ADDR_W = 4;
    localparam int LIST_W     = 8;
    // the step counter must reach LIST_W + 1 for a PUSH that includes LR
    localparam int STEP_W     = 4;

    localparam logic [REG_ADDR_W-1:0] SP_NUM = 4'd13;
    localparam logic [REG_ADDR_W-1:0] LR_NUM = 4'd14;

    // opcode class values, each compared against the top bits of the word
    localparam logic [1:0] OP_SHIFT_IMM = 2'b00;
    localparam logic [5:0] OP_DATA_PROC = 6'b010000;
    localparam logic [2:0] OP_LS_IMM    = 3'b011;
    localparam logic [4:0] OP_STM       = 5'b11000;
    localparam logic [4:0] OP_LDM       = 5'b11001;
    localparam logic [6:0] OP_PUSH      = 7'b1011010;

    // shift/immediate group, subcode in bits 13:11
    localparam logic [2:0] SH_LSL    = 3'b000;
    localparam logic [2:0] SH_LSR    = 3'b001;
    localparam logic [2:0] SH_ASR    = 3'b010;
    localparam logic [2:0] SH_ADDSUB = 3'b011;
    localparam logic [2:0] SH_MOV    = 3'b100;
    localparam logic [2:0] SH_CMP    = 3'b101;
    localparam logic [2:0] SH_ADD8   = 3'b110;
    localparam logic [2:0] SH_SUB8   = 3'b111;

    // add/sub form, bit 10 selects the 3-bit immediate and bit 9 selects subtract
    localparam logic [1:0] AS_ADD_REG  = 2'b00;
    localparam logic [1:0] AS_SUB_REG  = 2'b01;
    localparam logic [1:0] AS_ADD_IMM3 = 2'b10;
    localparam logic [1:0] AS_SUB_IMM3 = 2'b11;

    // data-processing subcode sits in bits 9:6
    localparam int DP_SUB_LSB = 6;
    localparam int DP_SUB_W   = 4;

    localparam logic [3:0] DP_AND = 4'h0;
    localparam logic [3:0] DP_EOR = 4'h1;
    localparam logic [3:0] DP_LSL = 4'h2;
    localparam logic [3:0] DP_LSR = 4'h3;
    localparam logic [3:0] DP_ASR = 4'h4;
    localparam logic [3:0] DP_ADC = 4'h5;
    localparam logic [3:0] DP_SBC = 4'h6;
    localparam logic [3:0] DP_ROR = 4'h7;
    localparam logic [3:0] DP_TST = 4'h8;
    localparam logic [3:0] DP_NEG = 4'h9;
    localparam logic [3:0] DP_CMP = 4'hA;
    localparam logic [3:0] DP_CMN = 4'hB;
    localparam logic [3:0] DP_ORR = 4'hC;
    localparam logic [3:0] DP_MUL = 4'hD;
    localparam logic [3:0] DP_BIC = 4'hE;
    localparam logic [3:0] DP_MVN = 4'hF;

    // single load/store with immediate offset, bit 11 set means load
    localparam int LS_LOAD_BIT = 11;

    typedef struct packed {
        logic [1:0] opcode;
        logic [2:0] subcode;
        // upper immediate bits, the form select for the add/sub group
        logic [1:0] imm;
        logic [2:0] rc;
        logic [2:0] rb;
        logic [2:0] ra;
    } alu_view_t;

    // bit 8 is LR for PUSH and the low bit of the base register for STM and LDM
    typedef struct packed {
        logic [4:0]        opcode;
        logic [1:0]        base_hi;
        logic              lr;
        logic [LIST_W-1:0] list;
    } blk_view_t;

    typedef union packed {
        alu_view_t alu;
        blk_view_t blk;
    } instr_u;

endpackage

/* design/ctrl_sig_pkg.sv */
package ctrl_sig_pkg;

    localparam int WORD_W = 32;

    // offsets count words, so a step of one is four bytes
    localparam int BYTE_SHIFT = 2;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_NOT = 4'd5,
        ALU_BIC = 4'd6,
        ALU_MUL = 4'd7,
        ALU_LSL = 4'd8,
        ALU_LSR = 4'd9,
        ALU_ASR = 4'd10,
        ALU_ROR = 4'd11,
        ALU_ADC = 4'd12,
        ALU_SBC = 4'd13
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_REG    = 2'd0,
        SRC_IMM    = 2'd1,
        SRC_ZERO   = 2'd2,
        SRC_OFFSET = 2'd3
    } src_sel_e;

    typedef enum logic {
        WB_ALU = 1'b0,
        WB_MEM = 1'b1
    } wb_src_e;

    typedef enum logic [1:0] {
        BLK_NONE = 2'd0,
        BLK_PUSH = 2'd1,
        BLK_STM  = 2'd2,
        BLK_LDM  = 2'd3
    } block_mode_e;

    typedef struct packed {
        logic     reg_we;
        logic     mem_we;
        logic     mem_re;
        logic     update_flags;
        alu_op_e  alu_op;
        src_sel_e src1_sel;
        src_sel_e src2_sel;
        wb_src_e  wb_src;
        // the register read for a store comes from the sequencer
        logic     addr2_from_seq;
        // the register written comes from the sequencer
        logic     dest_from_seq;
    } ctrl_word_t;

    // a bubble, nothing is written anywhere
    localparam ctrl_word_t CTRL_NOP = '{
        reg_we:         1'b0,
        mem_we:         1'b0,
        mem_re:         1'b0,
        update_flags:   1'b0,
        alu_op:         ALU_ADD,
        src1_sel:       SRC_REG,
        src2_sel:       SRC_REG,
        wb_src:         WB_ALU,
        addr2_from_seq: 1'b0,
        dest_from_seq:  1'b0
    };

endpackage

/* design/alu_op_decoder.sv */
module alu_op_decoder import thumb_isa_pkg::*, ctrl_sig_pkg::*; (
    input  instr_u     instr_i,
    output ctrl_word_t alu_ctrl_o
);

    logic [DP_SUB_W-1:0] dp_sub;

    always_comb begin
        dp_sub = instr_i[DP_SUB_LSB +: DP_SUB_W];

        alu_ctrl_o = CTRL_NOP;
        // every form in both groups sets flags and nearly all of them write Rd
        alu_ctrl_o.update_flags = 1'b1;
        alu_ctrl_o.reg_we = 1'b1;

        if (instr_i.alu.opcode == OP_SHIFT_IMM) begin
            alu_ctrl_o.src2_sel = SRC_IMM;
            case (instr_i.alu.subcode)
                SH_LSL: alu_ctrl_o.alu_op = ALU_LSL;
                SH_LSR: alu_ctrl_o.alu_op = ALU_LSR;
                SH_ASR: alu_ctrl_o.alu_op = ALU_ASR;
                SH_ADDSUB: begin
                    case (instr_i.alu.imm)
                        AS_ADD_REG: alu_ctrl_o.src2_sel = SRC_REG;
                        AS_SUB_REG: begin
                            alu_ctrl_o.alu_op = ALU_SUB;
                            alu_ctrl_o.src2_sel = SRC_REG;
                        end
                        AS_SUB_IMM3: alu_ctrl_o.alu_op = ALU_SUB;
                        default: alu_ctrl_o.alu_op = ALU_ADD;
                    endcase
                end
                // move is zero plus the immediate
                SH_MOV: alu_ctrl_o.src1_sel = SRC_ZERO;
                SH_CMP: begin
                    alu_ctrl_o.alu_op = ALU_SUB;
                    alu_ctrl_o.reg_we = 1'b0;
                end
                SH_SUB8: alu_ctrl_o.alu_op = ALU_SUB;
                default: alu_ctrl_o.alu_op = ALU_ADD;
            endcase
        end else begin
            case (dp_sub)
                DP_AND: alu_ctrl_o.alu_op = ALU_AND;
                DP_EOR: alu_ctrl_o.alu_op = ALU_XOR;
                DP_LSL: alu_ctrl_o.alu_op = ALU_LSL;
                DP_LSR: alu_ctrl_o.alu_op = ALU_LSR;
                DP_ASR: alu_ctrl_o.alu_op = ALU_ASR;
                DP_ADC: alu_ctrl_o.alu_op = ALU_ADC;
                DP_SBC: alu_ctrl_o.alu_op = ALU_SBC;
                DP_ROR: alu_ctrl_o.alu_op = ALU_ROR;
                DP_TST: begin
                    alu_ctrl_o.alu_op = ALU_AND;
                    alu_ctrl_o.reg_we = 1'b0;
                end
                // negate is zero minus the register
                DP_NEG: begin
                    alu_ctrl_o.alu_op = ALU_SUB;
                    alu_ctrl_o.src1_sel = SRC_ZERO;
                end
                DP_CMP: begin
                    alu_ctrl_o.alu_op = ALU_SUB;
                    alu_ctrl_o.reg_we = 1'b0;
                end
                DP_CMN: begin
                    alu_ctrl_o.alu_op = ALU_ADD;
                    alu_ctrl_o.reg_we = 1'b0;
                end
                DP_ORR: alu_ctrl_o.alu_op = ALU_OR;
                DP_MUL: alu_ctrl_o.alu_op = ALU_MUL;
                DP_BIC: alu_ctrl_o.alu_op = ALU_BIC;
                default: alu_ctrl_o.alu_op = ALU_NOT;
            endcase
        end
    end

endmodule

/* design/reg_list_sequencer.sv */
module reg_list_sequencer import thumb_isa_pkg::*, ctrl_sig_pkg::*; (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  advance_i,
    input  block_mode_e           block_mode_i,
    input  logic [LIST_W:0]       list_i,
    output logic [REG_ADDR_W-1:0] next_reg_o,
    output logic                  pending_o,
    output logic [STEP_W-1:0]     step_o
);

    logic [LIST_W:0]       list_eff;
    logic [LIST_W:0]       active;
    logic [LIST_W:0]       pick;
    logic [REG_ADDR_W-1:0] pick_idx;

    // set bits are registers not yet transferred
    logic [LIST_W:0]       remain_q;
    logic [STEP_W-1:0]     step_q;

    always_comb begin
        list_eff = list_i;
        // bit 8 only means LR for PUSH, otherwise it belongs to the base field
        if (block_mode_i != BLK_PUSH) begin
            list_eff[LIST_W] = 1'b0;
        end
        active = list_eff & remain_q;

        pick = '0;
        // once the list is exhausted the pointer rests on SP for the PUSH update
        pick_idx = SP_NUM;
        if (block_mode_i == BLK_LDM) begin
            // the last hit wins, so this finds the highest remaining register
            for (int i = 0; i <= LIST_W; i++) begin
                if (active[i]) begin
                    pick = '0;
                    pick[i] = 1'b1;
                    pick_idx = REG_ADDR_W'(i);
                end
            end
        end else begin
            for (int i = LIST_W; i >= 0; i--) begin
                if (active[i]) begin
                    pick = '0;
                    pick[i] = 1'b1;
                    pick_idx = REG_ADDR_W'(i);
                end
            end
        end

        if (pick[LIST_W]) begin
            pick_idx = LR_NUM;
        end
    end

    // every edge without advance restarts the walk for the next instruction
    always_ff @(posedge clk_i) begin
        if (reset_i || !advance_i) begin
            remain_q <= '1;
            step_q <= '0;
        end else begin
            remain_q <= remain_q & ~pick;
            step_q <= step_q + 1'b1;
        end
    end

    assign next_reg_o = pick_idx;
    assign pending_o = |active;
    assign step_o = step_q;

endmodule

/* design/transfer_offset_gen.sv */
module transfer_offset_gen import thumb_isa_pkg::*, ctrl_sig_pkg::*; (
    input  block_mode_e       block_mode_i,
    input  logic [LIST_W:0]   list_i,
    input  logic [STEP_W-1:0] step_i,
    input  logic              final_i,
    output logic [WORD_W-1:0] offset_o
);

    logic [LIST_W:0]   list_eff;
    logic [STEP_W-1:0] count;

    always_comb begin
        list_eff = list_i;
        if (block_mode_i != BLK_PUSH) begin
            list_eff[LIST_W] = 1'b0;
        end

        count = '0;
        for (int i = 0; i <= LIST_W; i++) begin
            count = count + STEP_W'(list_eff[i]);
        end

        // the final cycle moves the base by the whole block, the ALU picks the sign
        if (final_i) begin
            offset_o = WORD_W'(count) << BYTE_SHIFT;
        end else begin
            case (block_mode_i)
                BLK_STM: offset_o = WORD_W'(step_i) << BYTE_SHIFT;
                // these walk down from the top word of the block
                BLK_PUSH, BLK_LDM: begin
                    offset_o = (WORD_W'(count) - WORD_W'(step_i) - WORD_W'(1)) << BYTE_SHIFT;
                end
                default: offset_o = '0;
            endcase
        end
    end

endmodule

/* design/decode_ctrl.sv */
module decode_ctrl import thumb_isa_pkg::*, ctrl_sig_pkg::*; (
    input  logic        valid_i,
    input  instr_u      instr_i,
    input  ctrl_word_t  alu_ctrl_i,
    input  logic        pending_i,
    output ctrl_word_t  ctrl_o,
    output logic        stall_o,
    output logic        illegal_o,
    output logic        advance_o,
    output block_mode_e block_mode_o,
    output logic        final_o
);

    logic        is_alu;
    logic        is_ls;
    block_mode_e mode;
    logic [2:0]  base_reg;
    logic        base_in_list;

    // opcode classification, the wider patterns do not overlap the narrow ones
    always_comb begin
        is_alu = 1'b0;
        is_ls = 1'b0;
        mode = BLK_NONE;
        if (instr_i.alu.opcode == OP_SHIFT_IMM) begin
            is_alu = 1'b1;
        end else if (instr_i[INSTR_W-1 -: 6] == OP_DATA_PROC) begin
            is_alu = 1'b1;
        end else if (instr_i[INSTR_W-1 -: 3] == OP_LS_IMM) begin
            is_ls = 1'b1;
        end else if (instr_i.blk.opcode == OP_STM) begin
            mode = BLK_STM;
        end else if (instr_i.blk.opcode == OP_LDM) begin
            mode = BLK_LDM;
        end else if (instr_i[INSTR_W-1 -: 7] == OP_PUSH) begin
            mode = BLK_PUSH;
        end
    end

    assign base_reg = {instr_i.blk.base_hi, instr_i.blk.lr};
    assign base_in_list = instr_i.blk.list[base_reg];

    always_comb begin
        ctrl_o = CTRL_NOP;
        stall_o = 1'b0;
        illegal_o = 1'b0;
        advance_o = 1'b0;
        final_o = 1'b0;
        block_mode_o = BLK_NONE;

        if (valid_i) begin
            if (is_alu) begin
                ctrl_o = alu_ctrl_i;
            end else if (is_ls) begin
                ctrl_o.src2_sel = SRC_IMM;
                ctrl_o.wb_src = WB_MEM;
                if (instr_i[LS_LOAD_BIT]) begin
                    ctrl_o.mem_re = 1'b1;
                    ctrl_o.reg_we = 1'b1;
                end else begin
                    ctrl_o.mem_we = 1'b1;
                end
            end else if (mode != BLK_NONE) begin
                block_mode_o = mode;
                // one register per stalled cycle, then a single update cycle
                stall_o = pending_i;
                advance_o = pending_i;
                final_o = !pending_i;

                // PUSH addresses below SP, STM and LDM above the base
                ctrl_o.alu_op = (mode == BLK_PUSH) ? ALU_SUB : ALU_ADD;
                ctrl_o.src2_sel = SRC_OFFSET;

                if (pending_i) begin
                    if (mode == BLK_LDM) begin
                        ctrl_o.mem_re = 1'b1;
                        ctrl_o.reg_we = 1'b1;
                        ctrl_o.dest_from_seq = 1'b1;
                        ctrl_o.wb_src = WB_MEM;
                    end else begin
                        ctrl_o.mem_we = 1'b1;
                        ctrl_o.addr2_from_seq = 1'b1;
                    end
                end else begin
                    // a loaded base must not be overwritten by the write-back
                    ctrl_o.reg_we = (mode != BLK_LDM) || !base_in_list;
                    // the sequencer points at SP here, the base comes from the word
                    ctrl_o.dest_from_seq = (mode == BLK_PUSH);
                end
            end else begin
                illegal_o = 1'b1;
            end
        end
    end

endmodule

/* design/thumb_decode_top.sv */
module thumb_decode_top import thumb_isa_pkg::*, ctrl_sig_pkg::*; (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  valid_i,
    input  instr_u                instr_i,
    output ctrl_word_t            ctrl_o,
    output logic [WORD_W-1:0]     offset_o,
    output logic [REG_ADDR_W-1:0] seq_reg_o,
    output logic                  stall_o,
    output logic                  illegal_o
);

    ctrl_word_t        alu_ctrl;
    logic              advance;
    logic              pending;
    logic              final_step;
    block_mode_e       block_mode;
    logic [STEP_W-1:0] step;
    logic [LIST_W:0]   list;

    // low list plus bit 8, which each consumer qualifies with the mode
    assign list = {instr_i.blk.lr, instr_i.blk.list};

    alu_op_decoder i_alu_op_decoder (
        .instr_i    (instr_i),
        .alu_ctrl_o (alu_ctrl)
    );

    decode_ctrl i_decode_ctrl (
        .valid_i      (valid_i),
        .instr_i      (instr_i),
        .alu_ctrl_i   (alu_ctrl),
        .pending_i    (pending),
        .ctrl_o       (ctrl_o),
        .stall_o      (stall_o),
        .illegal_o    (illegal_o),
        .advance_o    (advance),
        .block_mode_o (block_mode),
        .final_o      (final_step)
    );

    reg_list_sequencer i_reg_list_sequencer (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .advance_i    (advance),
        .block_mode_i (block_mode),
        .list_i       (list),
        .next_reg_o   (seq_reg_o),
        .pending_o    (pending),
        .step_o       (step)
    );

    transfer_offset_gen i_transfer_offset_gen (
        .block_mode_i (block_mode),
        .list_i       (list),
        .step_i       (step),
        .final_i      (final_step),
        .offset_o     (offset_o)
    );

endmodule

/* bench/thumb_decode_props.sv */
module thumb_decode_props import thumb_isa_pkg::*, ctrl_sig_pkg::*; (
    input logic       clk_i,
    input logic       reset_i,
    input logic       valid_i,
    input instr_u     instr_i,
    input ctrl_word_t ctrl_i,
    input logic       stall_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // a stall only ever comes from a valid block transfer
    stall_needs_valid: assert property (
        @(posedge clk_i) disable iff (reset_i) !valid_i |-> !stall_i
    ) else $error("stall_o is high while valid_i is low");

    // a store step reads a register and writes memory, never the register file
    store_without_reg_write: assert property (
        @(posedge clk_i) disable iff (reset_i) (stall_i && ctrl_i.mem_we) |-> !ctrl_i.reg_we
    ) else $error("reg_we and mem_we are both high during a store step");

    // the fetch stage holds the word for as long as the stall lasts
    instr_held_in_stall: assert property (
        @(posedge clk_i) disable iff (reset_i) stall_i |=> $stable(instr_i)
    ) else $error("instr_i changed while stall_o was high");

endmodule

bind thumb_decode_top thumb_decode_props i_thumb_decode_props (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (valid_i),
    .instr_i (instr_i),
    .ctrl_i  (ctrl_o),
    .stall_i (stall_o)
);

/* bench/tb_thumb_decode.sv */
module tb_thumb_decode import thumb_isa_pkg::*, ctrl_sig_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 20;

    typedef struct packed {
        logic [15:0] instr;
        block_mode_e mode;
        logic [2:0]  base;
        logic        exp_illegal;
        ctrl_word_t  exp_ctrl;
        // bit 8 stands for LR
        logic [8:0]  exp_list;
    } row_t;

    logic              clk_i;
    logic              reset_i;
    logic              valid_i;
    instr_u            instr_i;
    ctrl_word_t        ctrl_o;
    logic [WORD_W-1:0] offset_o;
    logic [3:0]        seq_reg_o;
    logic              stall_o;
    logic              illegal_o;

    row_t        rows[$];
    logic [31:0] rng;

    thumb_decode_top i_thumb_decode_top (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .valid_i   (valid_i),
        .instr_i   (instr_i),
        .ctrl_o    (ctrl_o),
        .offset_o  (offset_o),
        .seq_reg_o (seq_reg_o),
        .stall_o   (stall_o),
        .illegal_o (illegal_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic check_ctrl(input ctrl_word_t exp, input string ctx);
        check_value(32'(ctrl_o.reg_we), 32'(exp.reg_we), {ctx, " reg_we"});
        check_value(32'(ctrl_o.mem_we), 32'(exp.mem_we), {ctx, " mem_we"});
        check_value(32'(ctrl_o.mem_re), 32'(exp.mem_re), {ctx, " mem_re"});
        check_value(32'(ctrl_o.update_flags), 32'(exp.update_flags), {ctx, " update_flags"});
        check_value(32'(ctrl_o.alu_op), 32'(exp.alu_op), {ctx, " alu_op"});
        check_value(32'(ctrl_o.src1_sel), 32'(exp.src1_sel), {ctx, " src1_sel"});
        check_value(32'(ctrl_o.src2_sel), 32'(exp.src2_sel), {ctx, " src2_sel"});
        check_value(32'(ctrl_o.wb_src), 32'(exp.wb_src), {ctx, " wb_src"});
        check_value(32'(ctrl_o.addr2_from_seq), 32'(exp.addr2_from_seq), {ctx, " addr2_from_seq"});
        check_value(32'(ctrl_o.dest_from_seq), 32'(exp.dest_from_seq), {ctx, " dest_from_seq"});
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // shift/immediate words use rc=1, rb=2, ra=3 and data-processing words use rs=4, rd=5
    function automatic logic [15:0] sh_word(input logic [2:0] sub, input logic [1:0] form);
        return {2'b00, sub, form, 3'd1, 3'd2, 3'd3};
    endfunction

    function automatic logic [15:0] dp_word(input logic [3:0] sub);
        return {6'b010000, sub, 3'd4, 3'd5};
    endfunction

    function automatic row_t alu_row(input logic [15:0] instr, input alu_op_e op,
                                     input src_sel_e s1, input src_sel_e s2, input logic we);
        row_t r;
        r = '0;
        r.instr = instr;
        r.exp_ctrl.alu_op = op;
        r.exp_ctrl.src1_sel = s1;
        r.exp_ctrl.src2_sel = s2;
        r.exp_ctrl.reg_we = we;
        r.exp_ctrl.update_flags = 1'b1;
        return r;
    endfunction

    function automatic row_t mem_row(input logic [15:0] instr, input logic load);
        row_t r;
        r = '0;
        r.instr = instr;
        r.exp_ctrl.src2_sel = SRC_IMM;
        r.exp_ctrl.wb_src = WB_MEM;
        r.exp_ctrl.mem_re = load;
        r.exp_ctrl.reg_we = load;
        r.exp_ctrl.mem_we = !load;
        return r;
    endfunction

    function automatic row_t illegal_row(input logic [15:0] instr);
        row_t r;
        r = '0;
        r.instr = instr;
        r.exp_illegal = 1'b1;
        return r;
    endfunction

    function automatic row_t block_row(input block_mode_e mode, input logic [2:0] base,
                                       input logic [8:0] list);
        row_t r;
        r = '0;
        r.mode = mode;
        r.base = base;
        r.exp_list = {1'b0, list[7:0]};
        case (mode)
            BLK_PUSH: begin
                r.instr = {7'b1011010, list};
                r.exp_list = list;
            end
            BLK_STM: r.instr = {5'b11000, base, list[7:0]};
            default: r.instr = {5'b11001, base, list[7:0]};
        endcase
        return r;
    endfunction

    // expected control word of one block-transfer cycle
    function automatic ctrl_word_t block_ctrl(input block_mode_e mode, input logic is_final,
                                              input logic base_write);
        ctrl_word_t c;
        c = '0;
        c.src2_sel = SRC_OFFSET;
        c.alu_op = (mode == BLK_PUSH) ? ALU_SUB : ALU_ADD;
        if (is_final) begin
            c.reg_we = base_write;
            c.dest_from_seq = (mode == BLK_PUSH);
        end else if (mode == BLK_LDM) begin
            c.mem_re = 1'b1;
            c.reg_we = 1'b1;
            c.dest_from_seq = 1'b1;
            c.wb_src = WB_MEM;
        end else begin
            c.mem_we = 1'b1;
            c.addr2_from_seq = 1'b1;
        end
        return c;
    endfunction

    task automatic build_table();
        rows.push_back(alu_row(sh_word(3'b000, 2'b01), ALU_LSL, SRC_REG, SRC_IMM, 1'b1));
        rows.push_back(alu_row(sh_word(3'b001, 2'b10), ALU_LSR, SRC_REG, SRC_IMM, 1'b1));
        rows.push_back(alu_row(sh_word(3'b010, 2'b00), ALU_ASR, SRC_REG, SRC_IMM, 1'b1));
        rows.push_back(alu_row(sh_word(3'b011, 2'b00), ALU_ADD, SRC_REG, SRC_REG, 1'b1));
        rows.push_back(alu_row(sh_word(3'b011, 2'b01), ALU_SUB, SRC_REG, SRC_REG, 1'b1));
        rows.push_back(alu_row(sh_word(3'b011, 2'b10), ALU_ADD, SRC_REG, SRC_IMM, 1'b1));
        rows.push_back(alu_row(sh_word(3'b011, 2'b11), ALU_SUB, SRC_REG, SRC_IMM, 1'b1));
        rows.push_back(alu_row(sh_word(3'b100, 2'b11), ALU_ADD, SRC_ZERO, SRC_IMM, 1'b1));
        rows.push_back(alu_row(sh_word(3'b101, 2'b01), ALU_SUB, SRC_REG, SRC_IMM, 1'b0));
        rows.push_back(alu_row(sh_word(3'b110, 2'b10), ALU_ADD, SRC_REG, SRC_IMM, 1'b1));
        rows.push_back(alu_row(sh_word(3'b111, 2'b00), ALU_SUB, SRC_REG, SRC_IMM, 1'b1));
        rows.push_back(alu_row(dp_word(4'h0), ALU_AND, SRC_REG, SRC_REG, 1'b1));
        rows.push_back(alu_row(dp_word(4'h1), ALU_XOR, SRC_REG, SRC_REG, 1'b1));
        rows.push_back(alu_row(dp_word(4'h2), ALU_LSL, SRC_REG, SRC_REG, 1'b1));
        rows.push_back(alu_row(dp_word(4'h3), ALU_LSR, SRC_REG, SRC_REG, 1'b1));
        rows.push_back(alu_row(dp_word(4'h4), ALU_ASR, SRC_REG, SRC_REG, 1'b1));
        rows.push_back(alu_row(dp_word(4'h5), ALU_ADC, SRC_REG, SRC_REG, 1'b1));
        rows.push_back(alu_row(dp_word(4'h6), ALU_SBC, SRC_REG, SRC_REG, 1'b1));
        rows.push_back(alu_row(dp_word(4'h7), ALU_ROR, SRC_REG, SRC_REG, 1'b1));
        rows.push_back(alu_row(dp_word(4'h8), ALU_AND, SRC_REG, SRC_REG, 1'b0));
        rows.push_back(alu_row(dp_word(4'h9), ALU_SUB, SRC_ZERO, SRC_REG, 1'b1));
        rows.push_back(alu_row(dp_word(4'hA), ALU_SUB, SRC_REG, SRC_REG, 1'b0));
        rows.push_back(alu_row(dp_word(4'hB), ALU_ADD, SRC_REG, SRC_REG, 1'b0));
        rows.push_back(alu_row(dp_word(4'hC), ALU_OR, SRC_REG, SRC_REG, 1'b1));
        rows.push_back(alu_row(dp_word(4'hD), ALU_MUL, SRC_REG, SRC_REG, 1'b1));
        rows.push_back(alu_row(dp_word(4'hE), ALU_BIC, SRC_REG, SRC_REG, 1'b1));
        rows.push_back(alu_row(dp_word(4'hF), ALU_NOT, SRC_REG, SRC_REG, 1'b1));
        rows.push_back(mem_row(16'h6A4B, 1'b1));
        rows.push_back(mem_row(16'h6123, 1'b0));
        rows.push_back(illegal_row(16'hE000));
        rows.push_back(illegal_row(16'h4400));
        rows.push_back(block_row(BLK_STM, 3'd2, 9'h0A6));
        rows.push_back(block_row(BLK_STM, 3'd1, 9'h000));
        rows.push_back(block_row(BLK_LDM, 3'd3, 9'h00F));
        rows.push_back(block_row(BLK_LDM, 3'd5, 9'h016));
        rows.push_back(block_row(BLK_PUSH, 3'd0, 9'h111));
        rows.push_back(block_row(BLK_PUSH, 3'd0, 9'h100));
        // random lists for each block form
        for (int i = 0; i < 4; i++) begin
            rng = xorshift32(rng);
            rows.push_back(block_row(BLK_STM, rng[10:8], rng[8:0]));
            rng = xorshift32(rng);
            rows.push_back(block_row(BLK_LDM, rng[10:8], rng[8:0]));
            rng = xorshift32(rng);
            rows.push_back(block_row(BLK_PUSH, 3'd0, rng[8:0]));
        end
    endtask

    task automatic apply_row(input row_t row);
        int         order[$];
        int         count;
        int         k;
        logic       base_write;
        ctrl_word_t exp;
        @(posedge clk_i);
        #5;
        instr_i = row.instr;
        valid_i = 1'b1;
        @(negedge clk_i);
        if (row.mode == BLK_NONE) begin
            check_ctrl(row.exp_ctrl, "single");
            check_value(32'(illegal_o), 32'(row.exp_illegal), "illegal_o");
            check_value(32'(stall_o), 32'd0, "stall_o on a single-cycle word");
        end else begin
            // STM and PUSH walk upwards, LDM walks downwards
            if (row.mode == BLK_LDM) begin
                for (int i = 7; i >= 0; i--) begin
                    if (row.exp_list[i]) order.push_back(i);
                end
            end else begin
                for (int i = 0; i <= 8; i++) begin
                    if (row.exp_list[i]) order.push_back((i == 8) ? 14 : i);
                end
            end
            count = order.size();
            base_write = (row.mode != BLK_LDM) || !row.exp_list[row.base];
            k = 0;
            while (stall_o) begin
                if (k >= WAIT_LIMIT) begin
                    $display("Timeout: stall_o stayed high for %0d cycles", WAIT_LIMIT);
                    $display("Simulation FAILED");
                    $fatal(1, "block transfer never finished");
                end
                check_value(32'(k < count), 32'd1, "stall_o high past the end of the list");
                exp = block_ctrl(row.mode, 1'b0, base_write);
                check_ctrl(exp, "block step");
                check_value(32'(seq_reg_o), 32'(order[k]), "seq_reg_o");
                if (row.mode == BLK_STM) begin
                    check_value(offset_o, 32'(4 * k), "step offset");
                end else begin
                    check_value(offset_o, 32'(4 * (count - 1 - k)), "step offset");
                end
                k++;
                @(posedge clk_i);
                @(negedge clk_i);
            end
            check_value(32'(k), 32'(count), "stall cycles");
            exp = block_ctrl(row.mode, 1'b1, base_write);
            check_ctrl(exp, "block final");
            check_value(offset_o, 32'(4 * count), "final offset");
            check_value(32'(illegal_o), 32'd0, "illegal_o on a block word");
            if (row.mode == BLK_PUSH) begin
                check_value(32'(seq_reg_o), 32'd13, "final PUSH register");
            end
        end
    endtask

    initial begin
        reset_i = 1'b1;
        valid_i = 1'b0;
        instr_i = '0;
        rng = 32'd20;
        build_table();
        repeat (8) @(posedge clk_i);
        #5;
        reset_i = 1'b0;
        @(negedge clk_i);
        check_value(32'(stall_o), 32'd0, "stall_o after reset");
        check_value(32'(ctrl_o.reg_we), 32'd0, "reg_we after reset");
        check_value(32'(ctrl_o.mem_we), 32'd0, "mem_we after reset");
        check_value(32'(ctrl_o.mem_re), 32'd0, "mem_re after reset");
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        @(posedge clk_i);
        #5;
        valid_i = 1'b0;
        @(negedge clk_i);
        check_value(32'(stall_o), 32'd0, "stall_o when idle");
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* compile.f */
design/thumb_isa_pkg.sv
design/ctrl_sig_pkg.sv
design/alu_op_decoder.sv
design/reg_list_sequencer.sv
design/transfer_offset_gen.sv
design/decode_ctrl.sv
design/thumb_decode_top.sv
bench/thumb_decode_props.sv
bench/tb_thumb_decode.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps \
    -f compile.f --top-module tb_thumb_decode -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vtb_thumb_decode
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi

exit 0
